/* sccb_pkg.sv */
package sccb_pkg;

    // one data or address byte on the wire
    typedef logic [7:0] sccb_byte_t;
    typedef logic [6:0] dev_id_t;

    localparam dev_id_t CAM_DEV_ID = 7'h30; // 0x60 write / 0x61 read on the wire

    // sccb clock timing, 50 MHz in
    localparam int SCCB_HALF_CYCLES = 62; // ~400 kHz
    typedef logic [$clog2(SCCB_HALF_CYCLES)-1:0] half_cnt_t;
    localparam half_cnt_t HALF_CNT_LAST  = half_cnt_t'(SCCB_HALF_CYCLES - 1);
    localparam half_cnt_t SCCB_MID_CYCLE = half_cnt_t'(SCCB_HALF_CYCLES / 2 - 1);

    typedef logic [2:0] bit_cnt_t; // bit position within a byte

    // register addresses from here up are refused by the camera model
    localparam sccb_byte_t NACK_REG_MIN = 8'hF0;

    typedef struct packed {
        logic       rw;       // 1 = read
        sccb_byte_t reg_addr;
        sccb_byte_t wr_data;
        logic       start;    // single cycle request
    } sccb_cmd_t;

    typedef struct packed {
        sccb_byte_t reg_addr;
        sccb_byte_t data;
    } init_entry_t;

    localparam int INIT_LEN = 6;
    typedef logic [$clog2(INIT_LEN)-1:0] init_idx_t;
    localparam init_idx_t INIT_LAST = init_idx_t'(INIT_LEN - 1);

    // sensor bank setup written once after reset
    localparam init_entry_t INIT_TABLE [INIT_LEN] = '{
        '{8'h12, 8'h40},  // com7, svga mode
        '{8'h11, 8'h01},  // clkrc prescaler
        '{8'h17, 8'h11},  // hstart
        '{8'h18, 8'h75},  // hstop
        '{8'h32, 8'h36},  // reg32, href lsbs
        '{8'h19, 8'h01}   // vstart
    };

    typedef enum logic [3:0] {
        IDLE, START, SEND_BYTE, CHECK_ACK, RESTART, RECV_BYTE, SEND_NA, STOP, DONE
    } ctrl_state_t;

endpackage

/* sccb_clk_gen.sv */
`timescale 1ns/1ns

module sccb_clk_gen import sccb_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    output logic scl_lvl_o,  // free running sccb clock level
    output logic mid_stb_o   // one pulse mid low phase
);

    half_cnt_t cnt_q;  // position within the current half period

    // half period counter, level flips on terminal count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q     <= '0;
            scl_lvl_o <= 1'b1;  // bus idles high
        end else begin
            if (cnt_q == HALF_CNT_LAST) begin
                cnt_q     <= '0;
                scl_lvl_o <= ~scl_lvl_o;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // data change point, only while the clock is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_stb_o <= 1'b0;
        end else begin
            mid_stb_o <= (cnt_q == SCCB_MID_CYCLE) && !scl_lvl_o;
        end
    end

    // note: strobe lands one cycle after the compare hits,
    // still well inside the low half

endmodule

/* sccb_ctrl.sv */
`timescale 1ns/1ns

module sccb_ctrl import sccb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       scl_lvl_i,
    input  logic       mid_stb_i,
    input  sccb_cmd_t  cmd_i,
    output logic       busy_o,
    output logic       done_o,
    output logic       ack_err_o,
    output sccb_byte_t rd_data_o,
    output logic       sioc_o,
    inout  wire        siod_io
);

    ctrl_state_t state;
    logic [1:0]  step;          // sub-step inside ack, na and stop slots
    logic [1:0]  byte_idx;      // 0 id, 1 reg addr, 2 data
    bit_cnt_t    bit_cnt;
    sccb_byte_t  shift_q;
    logic        rd_part;       // second transaction of a read
    logic        restart_pend;  // stop is followed by a restart
    logic        sda_low;       // pull siod down
    logic        sioc_en;       // sioc follows the bit clock
    logic        scl_d;
    logic        scl_rise;
    logic        scl_fall;
    logic        sda_in;
    logic        err_q;
    sccb_byte_t  rd_data_q;
    logic        rw_q;
    sccb_byte_t  reg_q;
    sccb_byte_t  wdat_q;

    assign siod_io  = sda_low ? 1'b0 : 1'bz;  // open drain, pull-up makes the high
    assign sda_in   = siod_io;
    assign sioc_o   = sioc_en ? scl_lvl_i : 1'b1;
    assign scl_rise = scl_lvl_i & ~scl_d;
    assign scl_fall = ~scl_lvl_i & scl_d;

    assign busy_o    = (state != IDLE);
    assign done_o    = (state == DONE);  // single cycle, state lasts one clk
    assign ack_err_o = err_q;
    assign rd_data_o = rd_data_q;

    // command payload, captured on an accepted start
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_i.start) begin
            rw_q   <= cmd_i.rw;
            reg_q  <= cmd_i.reg_addr;
            wdat_q <= cmd_i.wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            step         <= '0;
            byte_idx     <= '0;
            bit_cnt      <= '0;
            shift_q      <= '0;
            rd_part      <= 1'b0;
            restart_pend <= 1'b0;
            sda_low      <= 1'b0;
            sioc_en      <= 1'b0;
            scl_d        <= 1'b1;
            err_q        <= 1'b0;
            rd_data_q    <= '0;
        end else begin
            scl_d <= scl_lvl_i;
            case (state)
                IDLE: begin
                    if (cmd_i.start) begin
                        state        <= START;
                        step         <= '0;
                        byte_idx     <= '0;
                        rd_part      <= 1'b0;
                        restart_pend <= 1'b0;
                        err_q        <= 1'b0;  // error is per transaction
                    end
                end
                START, RESTART: begin
                    // sda falls while sioc is still held high
                    if (mid_stb_i) begin
                        sda_low <= 1'b1;
                        shift_q <= {CAM_DEV_ID, rd_part};  // rd_part selects 0x61
                        bit_cnt <= '0;
                        state   <= SEND_BYTE;
                    end
                end
                SEND_BYTE: begin
                    if (scl_fall) sioc_en <= 1'b1;  // clock released after start
                    if (mid_stb_i) begin
                        sda_low <= ~shift_q[7];  // msb first
                        shift_q <= {shift_q[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= CHECK_ACK;
                            step  <= '0;
                        end
                    end
                end
                CHECK_ACK: begin
                    if (step == 2'd0 && mid_stb_i) begin
                        sda_low <= 1'b0;  // hand the ninth bit to the slave
                        step    <= 2'd1;
                    end else if (step == 2'd1 && scl_rise) begin
                        step    <= '0;
                        bit_cnt <= '0;
                        if (sda_in) begin
                            err_q <= 1'b1;  // no ack, abandon with a stop
                            state <= STOP;
                        end else if (rd_part) begin
                            state <= RECV_BYTE;
                        end else if (byte_idx == 2'd0) begin
                            shift_q  <= reg_q;
                            byte_idx <= 2'd1;
                            state    <= SEND_BYTE;
                        end else if (byte_idx == 2'd1 && !rw_q) begin
                            shift_q  <= wdat_q;
                            byte_idx <= 2'd2;
                            state    <= SEND_BYTE;
                        end else begin
                            restart_pend <= rw_q;  // read goes on after the stop
                            state        <= STOP;
                        end
                    end
                end
                RECV_BYTE: begin
                    if (scl_rise) begin
                        shift_q <= {shift_q[6:0], sda_in};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            rd_data_q <= {shift_q[6:0], sda_in};
                            state     <= SEND_NA;
                            step      <= '0;
                        end
                    end
                end
                SEND_NA: begin
                    // ninth bit left high, single byte read
                    if (step == 2'd0 && mid_stb_i) begin
                        sda_low <= 1'b0;
                        step    <= 2'd1;
                    end else if (step == 2'd1 && scl_rise) begin
                        step  <= '0;
                        state <= STOP;
                    end
                end
                STOP: begin
                    if (step == 2'd0 && mid_stb_i) begin
                        sda_low <= 1'b1;  // sda low before sioc rises
                        step    <= 2'd1;
                    end else if (step == 2'd1 && scl_rise) begin
                        sioc_en <= 1'b0;  // park sioc high
                        step    <= 2'd2;
                    end else if (step == 2'd2 && mid_stb_i) begin
                        sda_low <= 1'b0;  // sda rises with sioc high
                        step    <= '0;
                        if (restart_pend) begin
                            restart_pend <= 1'b0;
                            rd_part      <= 1'b1;
                            state        <= RESTART;
                        end else begin
                            state <= DONE;
                        end
                    end
                end
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* sccb_init_seq.sv */
`timescale 1ns/1ns

module sccb_init_seq import sccb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  sccb_cmd_t host_cmd_i,
    input  logic      ctrl_busy_i,
    input  logic      ctrl_done_i,
    input  logic      ctrl_ack_err_i,
    output sccb_cmd_t ctrl_cmd_o,
    output logic      init_done_o,
    output logic      busy_o,
    output logic      done_o,
    output logic      ack_error_o
);

    init_idx_t idx_q;        // current table entry
    logic      issue_q;      // start pulse for the current entry
    logic      init_done_q;
    logic      fin_q;        // single pulse as init ends
    logic      err_sticky;   // any nack during init
    logic      host_seen;    // a host command has been accepted
    logic      host_start;

    // host start only once init is over and the controller is free
    assign host_start = init_done_q & host_cmd_i.start & ~ctrl_busy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q       <= '0;
            issue_q     <= 1'b1;  // entry 0 goes out right after reset
            init_done_q <= 1'b0;
            fin_q       <= 1'b0;
            err_sticky  <= 1'b0;
            host_seen   <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            fin_q   <= 1'b0;
            if (!init_done_q && ctrl_done_i) begin
                err_sticky <= err_sticky | ctrl_ack_err_i;
                if (idx_q == INIT_LAST) begin
                    init_done_q <= 1'b1;  // stays set until reset
                    fin_q       <= 1'b1;
                end else begin
                    idx_q   <= idx_q + 1'b1;
                    issue_q <= 1'b1;  // next entry the cycle after done
                end
            end
            if (host_start) host_seen <= 1'b1;
        end
    end

    // table writes during init, host commands afterwards
    always_comb begin
        ctrl_cmd_o = host_cmd_i;
        if (init_done_q) begin
            ctrl_cmd_o.start = host_start;
        end else begin
            ctrl_cmd_o.rw       = 1'b0;
            ctrl_cmd_o.reg_addr = INIT_TABLE[idx_q].reg_addr;
            ctrl_cmd_o.wr_data  = INIT_TABLE[idx_q].data;
            ctrl_cmd_o.start    = issue_q;
        end
    end

    assign init_done_o = init_done_q;
    assign busy_o      = ~init_done_q | ctrl_busy_i;

    // per entry done pulses stay hidden, one done for the whole init
    assign done_o = fin_q | (init_done_q & ctrl_done_i);

    // init result held until the host issues its first command
    assign ack_error_o = host_seen ? ctrl_ack_err_i : err_sticky;

endmodule

/* sccb_top.sv */
`timescale 1ns/1ns

module sccb_top import sccb_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  sccb_cmd_t  host_cmd_i,
    output logic       busy_o,
    output logic       done_o,
    output logic       ack_error_o,
    output sccb_byte_t rd_data_o,
    output logic       init_done_o,
    output logic       sioc_o,
    inout  wire        siod_io
);

    logic      scl_lvl;     // free running bit clock
    logic      mid_stb;     // data change strobe
    sccb_cmd_t ctrl_cmd;
    logic      ctrl_busy;
    logic      ctrl_done;
    logic      ctrl_ack_err;

    sccb_clk_gen u_clk_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl_lvl_o (scl_lvl),
        .mid_stb_o (mid_stb)
    );

    // init table first, host commands after
    sccb_init_seq u_init_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .host_cmd_i     (host_cmd_i),
        .ctrl_busy_i    (ctrl_busy),
        .ctrl_done_i    (ctrl_done),
        .ctrl_ack_err_i (ctrl_ack_err),
        .ctrl_cmd_o     (ctrl_cmd),
        .init_done_o    (init_done_o),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .ack_error_o    (ack_error_o)
    );

    sccb_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .scl_lvl_i (scl_lvl),
        .mid_stb_i (mid_stb),
        .cmd_i     (ctrl_cmd),
        .busy_o    (ctrl_busy),
        .done_o    (ctrl_done),
        .ack_err_o (ctrl_ack_err),
        .rd_data_o (rd_data_o),  // held from done until the next start
        .sioc_o    (sioc_o),
        .siod_io   (siod_io)
    );

endmodule

/* tb_sccb_slave.sv */
`timescale 1ns/1ns

module tb_sccb_slave import sccb_pkg::*; (
    input  logic sioc_i,
    inout  wire  siod_io
);

    sccb_byte_t regs [256];  // camera register file
    sccb_byte_t reg_ptr;     // set by the register address byte
    sccb_byte_t rx_sh;       // byte from the master
    sccb_byte_t tx_sh;       // byte back to the master
    int         clk_n;       // sioc rises in the current 9 bit frame
    int         byte_n;      // frames since the last start
    logic       active;
    logic       rd_mode;     // id carried the read bit
    logic       tx_phase;    // slave owns the 8 data bits
    logic       pull_low;

    assign siod_io = pull_low ? 1'b0 : 1'bz;  // open drain like the sensor

    initial begin
        active   = 1'b0;
        pull_low = 1'b0;
        tx_phase = 1'b0;
        for (int i = 0; i < 256; i++) begin
            regs[i] = sccb_byte_t'(i) ^ 8'hA5;  // power-on content
        end
    end

    // start or repeated start, siod falls with sioc high
    always @(negedge siod_io) begin
        if (sioc_i === 1'b1) begin
            active   = 1'b1;
            rd_mode  = 1'b0;
            tx_phase = 1'b0;
            clk_n    = 0;
            byte_n   = 0;
        end
    end

    always @(posedge siod_io) begin
        if (sioc_i === 1'b1) active = 1'b0;  // stop
    end

    always @(posedge sioc_i) begin
        if (active) begin
            if (clk_n < 8) rx_sh = {rx_sh[6:0], siod_io};  // msb first
            clk_n++;
        end
    end

    // siod only moves while sioc is low
    always @(negedge sioc_i) begin
        if (active && clk_n == 8) begin
            if (tx_phase) begin
                pull_low = 1'b0;  // ninth bit belongs to the master
            end else if (byte_n == 0) begin
                rd_mode  = rx_sh[0];
                pull_low = (rx_sh[7:1] == CAM_DEV_ID);
            end else if (byte_n == 1) begin
                reg_ptr  = rx_sh;
                pull_low = (rx_sh < NACK_REG_MIN);  // high registers refused
            end else begin
                regs[reg_ptr] = rx_sh;
                pull_low      = 1'b1;
            end
        end else if (active && clk_n == 9) begin
            // end of frame, release ack and maybe put out the read byte
            clk_n    = 0;
            byte_n++;
            tx_phase = rd_mode && byte_n == 1;
            tx_sh    = regs[reg_ptr];
            pull_low = tx_phase && !tx_sh[7];
        end else if (active && tx_phase && clk_n > 0) begin
            tx_sh    = {tx_sh[6:0], 1'b0};
            pull_low = !tx_sh[7];
        end
    end

endmodule

/* tb_sccb.sv */
`timescale 1ns/1ns

module tb_sccb import sccb_pkg::*; ();

    logic       clk;
    logic       rst_n;
    sccb_cmd_t  host_cmd;
    logic       busy;
    logic       done;
    logic       ack_err;
    logic       init_done;
    logic       sioc;
    sccb_byte_t rd_data;
    tri1        siod;  // pull-up on the open drain line

    sccb_byte_t exp_regs [256];  // expected register contents
    int         err_cnt   = 0;
    int         tests_ok  = 0;
    int         tests_bad = 0;
    int         done_cnt  = 0;
    int         cycle_cnt = 0;

    sccb_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_cmd_i  (host_cmd),
        .busy_o      (busy),
        .done_o      (done),
        .ack_error_o (ack_err),
        .rd_data_o   (rd_data),
        .init_done_o (init_done),
        .sioc_o      (sioc),
        .siod_io     (siod)
    );

    tb_sccb_slave slave (.sioc_i(sioc), .siod_io(siod));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (rst_n && done) done_cnt <= done_cnt + 1;
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |-> init_done) else begin
        err_cnt++;
        $display("Fail @ %0t: done_o before init_done_o", $time);
    end

    // bus clock parked whenever nothing is running
    assert property (@(posedge clk) disable iff (!rst_n) !busy |-> sioc) else begin
        err_cnt++;
        $display("Fail @ %0t: sioc_o low while busy_o low", $time);
    end

    task automatic check_that(input logic ok, input string what);
        assert (ok) else begin
            err_cnt++;
            $display("Fail @ %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d error(s)", name, err_cnt - errs_before);
        end
    endtask

    task automatic check_reset_outputs(input string when_s);
        check_that(sioc === 1'b1, {"sioc_o not high ", when_s});
        check_that(siod === 1'b1, {"siod_io not released ", when_s});
        check_that(done === 1'b0, {"done_o set ", when_s});
        check_that(ack_err === 1'b0, {"ack_error_o set ", when_s});
        check_that(init_done === 1'b0, {"init_done_o set ", when_s});
        check_that(busy === 1'b1, {"busy_o not high ", when_s});
    endtask

    task automatic pulse_start(input logic rw, input sccb_byte_t addr, input sccb_byte_t data);
        @(posedge clk);
        #2;
        host_cmd.rw       = rw;
        host_cmd.reg_addr = addr;
        host_cmd.wr_data  = data;
        host_cmd.start    = 1'b1;
        @(posedge clk);
        #2;
        host_cmd.start = 1'b0;  // one cycle only
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!done);
    endtask

    task automatic run_cmd(input logic rw, input sccb_byte_t addr, input sccb_byte_t data);
        while (busy) @(negedge clk);
        pulse_start(rw, addr, data);
        wait_done();
    endtask

    // watchdog, 60 transactions of 30 bits, doubled for restarts and stop slots
    initial begin
        while (cycle_cnt < 60 * 30 * 2 * SCCB_HALF_CYCLES * 2) @(posedge clk);
        $display("timeout after %0d cycles, a transaction never completed", cycle_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int         errs;
        int         base;
        sccb_byte_t addr;
        sccb_byte_t data;
        sccb_byte_t keep;
        void'($urandom(32'hb804_494b));
        rst_n    = 1'b0;
        host_cmd = '0;

        errs = err_cnt;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_reset_outputs("during reset");
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_outputs("after reset");
        report_test("reset state", errs);

        errs = err_cnt;
        while (!init_done) @(negedge clk);
        check_that(ack_err === 1'b0, "ack_error_o set at end of init");
        for (int i = 0; i < INIT_LEN; i++) begin
            check_that(slave.regs[INIT_TABLE[i].reg_addr] === INIT_TABLE[i].data,
                $sformatf("init reg 0x%02h not written", INIT_TABLE[i].reg_addr));
            exp_regs[INIT_TABLE[i].reg_addr] = INIT_TABLE[i].data;
        end
        report_test("init sequence", errs);

        errs = err_cnt;
        for (int n = 0; n < 20; n++) begin
            addr = sccb_byte_t'($urandom % NACK_REG_MIN);
            data = sccb_byte_t'($urandom);
            run_cmd(1'b0, addr, data);
            exp_regs[addr] = data;
            check_that(ack_err === 1'b0, "ack_error_o on a good write");
            run_cmd(1'b1, addr, 8'h00);
            check_that(ack_err === 1'b0, "ack_error_o on a good read");
            check_that(rd_data === exp_regs[addr], $sformatf("read 0x%02h gave 0x%02h, want 0x%02h",
                addr, rd_data, exp_regs[addr]));
        end
        report_test("write then read", errs);

        errs = err_cnt;
        addr = sccb_byte_t'(NACK_REG_MIN + $urandom % 16);
        keep = slave.regs[addr];
        run_cmd(1'b0, addr, 8'h5C);
        check_that(ack_err === 1'b1, "no ack_error_o on a refused write");
        check_that(slave.regs[addr] === keep, "refused write changed the register");
        run_cmd(1'b1, addr, 8'h00);
        check_that(ack_err === 1'b1, "no ack_error_o on a refused read");
        addr = sccb_byte_t'($urandom % NACK_REG_MIN);
        run_cmd(1'b0, addr, 8'h3E);
        exp_regs[addr] = 8'h3E;
        check_that(ack_err === 1'b0, "ack_error_o still set after a good write");
        report_test("nack reporting", errs);

        errs = err_cnt;
        addr = sccb_byte_t'($urandom % NACK_REG_MIN);
        data = sccb_byte_t'($urandom);
        keep = slave.regs[addr ^ 8'h01];
        while (busy) @(negedge clk);
        base = done_cnt;
        pulse_start(1'b0, addr, data);
        check_that(busy === 1'b1, "busy_o low after an accepted start");
        pulse_start(1'b0, addr ^ 8'h01, ~data);  // must be dropped
        wait_done();
        exp_regs[addr] = data;
        repeat (36 * 2 * SCCB_HALF_CYCLES) @(negedge clk);  // room for a stray second transaction
        check_that(done_cnt == base + 1, $sformatf("%0d done pulses for one start", done_cnt - base));
        check_that(slave.regs[addr] === exp_regs[addr], "accepted write missing");
        check_that(slave.regs[addr ^ 8'h01] === keep, "dropped start reached the bus");
        report_test("busy rule", errs);

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* all.f */
sccb_pkg.sv
sccb_clk_gen.sv
sccb_ctrl.sv
sccb_init_seq.sv
sccb_top.sv
tb_sccb_slave.sv
tb_sccb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sccb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  := Simulation completed successfully
SRCS      := $(wildcard *.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "run did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
